// File: flist.f
design/pe_pkg.sv
design/pe_stage_if.sv
design/pe_stage_ctrl.sv
design/pe_mult_tree.sv
design/pe_act_tree.sv
design/pe_group_acc.sv
design/pe_result_stage.sv
design/pe_dot8.sv
sim/pe_checker.sv
sim/pe_dot8_properties.sv
sim/tb_pe_dot8.sv

// File: Bender.yml
package:
  name: pe_dot8

sources:
  # processing element RTL, package and interface first
  - files:
      - design/pe_pkg.sv
      - design/pe_stage_if.sv
      - design/pe_stage_ctrl.sv
      - design/pe_mult_tree.sv
      - design/pe_act_tree.sv
      - design/pe_group_acc.sv
      - design/pe_result_stage.sv
      - design/pe_dot8.sv
  # testbench, checker and bound assertions
  - target: simulation
    files:
      - sim/pe_checker.sv
      - sim/pe_dot8_properties.sv
      - sim/tb_pe_dot8.sv

// File: sim/tb_pe_dot8.sv
// testbench for the dot-product processing element
// seeded random groups checked by pe_checker and bound assertions

module tb_pe_dot8 import pe_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED = 32'hda15_40d5;
	localparam int N_SINGLE = 20;
	localparam int N_MULTI  = 20;
	localparam int N_B2B    = 32;
	localparam int N_AFTER  = 6;
	// worst-case idle cycles spent waiting for one batch of results
	localparam int DRAIN    = 24;

	// ============================================================
	// run length and watchdog limit
	// ============================================================

	// reset, singles with gaps, multi groups with gaps, back-to-back,
	// max groups, reset test, groups after reset, drains, closing
	localparam int STIM_CYCLES = 4 + N_SINGLE*4 + N_MULTI*48 + N_B2B + 4*32 + 24
		+ N_AFTER*48 + 5*DRAIN + 4;
	localparam int TIMEOUT = 2*STIM_CYCLES + 50;

	logic     clk = 1'b0;
	logic     reset;
	logic     valid_in;
	logic     final_in;
	ele_row_t act_row;
	ele_row_t ker_row;
	bias_t    bias_in;
	logic     valid_out;
	acc_t     mac_sum;
	acc_t     act_sum;
	logic     end_of_test;
	int       check_errors;
	int       pending;
	int       cycle_count = 0;

	always #4 clk = ~clk;

	pe_dot8 UUT (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.final_in  (final_in),
		.act_row   (act_row),
		.ker_row   (ker_row),
		.bias_in   (bias_in),
		.valid_out (valid_out),
		.mac_sum   (mac_sum),
		.act_sum   (act_sum)
	);

	pe_checker u_checker (
		.clk           (clk),
		.reset         (reset),
		.valid_in      (valid_in),
		.final_in      (final_in),
		.act_row       (act_row),
		.ker_row       (ker_row),
		.bias_in       (bias_in),
		.valid_out     (valid_out),
		.mac_sum       (mac_sum),
		.act_sum       (act_sum),
		.end_of_test   (end_of_test),
		.error_count   (check_errors),
		.pending_count (pending)
	);

	bind pe_dot8 pe_dot8_properties props (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.final_in  (final_in),
		.valid_out (valid_out),
		.mac_sum   (mac_sum),
		.act_sum   (act_sum)
	);

	// watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT) begin
			$display("timeout, run still going after %0d cycles", TIMEOUT);
			$display("sim failed");
			$finish;
		end
	end

	// ============================================================
	// stimulus tasks
	// ============================================================

	function automatic ele_row_t random_row();
		return {$urandom, $urandom};
	endfunction

	// one valid beat whose bias only counts when it is final
	task automatic drive_beat(input logic fin, input logic all_max, input bias_t bias);
		@(posedge clk);
		valid_in <= 1'b1;
		final_in <= fin;
		act_row  <= all_max ? '1 : random_row();
		ker_row  <= all_max ? '1 : random_row();
		bias_in  <= fin ? bias : bias_t'($urandom);
	endtask

	// idle cycles carry junk on data and final
	task automatic drive_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			valid_in <= 1'b0;
			final_in <= 1'($urandom);
			act_row  <= random_row();
			ker_row  <= random_row();
			bias_in  <= bias_t'($urandom);
		end
	endtask

	// n beats with up to max_gap idles after each non-final beat
	task automatic drive_group(input int n, input int max_gap, input logic all_max,
		input bias_t bias);
		for (int i = 0; i < n; i++) begin
			drive_beat(i == n - 1, all_max, bias);
			if (i < n - 1 && max_gap > 0) begin
				drive_idle($urandom_range(max_gap, 0));
			end
		end
	endtask

	// idle until every expected result has left the DUT
	task automatic wait_results();
		drive_idle(2);
		while (pending != 0) begin
			drive_idle(1);
		end
		drive_idle(4);
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		void'($urandom(SEED));
		reset       = 1'b1;
		valid_in    = 1'b0;
		final_in    = 1'b0;
		act_row     = '0;
		ker_row     = '0;
		bias_in     = '0;
		end_of_test = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// single-beat groups
		for (int g = 0; g < N_SINGLE; g++) begin
			drive_group(1, 0, 1'b0, bias_t'($urandom));
			drive_idle($urandom_range(3, 0));
		end
		wait_results();

		// groups of 2 to 16 beats with idles inside
		for (int g = 0; g < N_MULTI; g++) begin
			drive_group($urandom_range(16, 2), 2, 1'b0, bias_t'($urandom));
		end
		wait_results();

		// a final on every cycle keeps several results in flight
		for (int g = 0; g < N_B2B; g++) begin
			drive_beat(1'b1, 1'b0, bias_t'($urandom));
		end
		wait_results();

		// all elements 255 with extreme biases
		drive_group(16, 0, 1'b1, 32'h7fff_ffff);
		drive_group(16, 0, 1'b1, 32'h8000_0000);
		drive_group(16, 1, 1'b1, 32'hffff_ffff);
		drive_group(16, 0, 1'b1, 32'h0000_0000);
		wait_results();

		// reset with one result in flight and a group half done
		drive_group(3, 0, 1'b0, bias_t'($urandom));
		repeat (4) drive_beat(1'b0, 1'b0, '0);
		reset <= 1'b1;
		repeat (3) drive_beat(1'b0, 1'b0, '0);
		reset <= 1'b0;
		// nothing may come out here
		drive_idle(12);
		for (int g = 0; g < N_AFTER; g++) begin
			drive_group($urandom_range(16, 2), 2, 1'b0, bias_t'($urandom));
		end
		wait_results();

		end_of_test <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		$display("errors: checker %0d, assertions %0d", check_errors, UUT.props.fail_count);
		if (check_errors == 0 && UUT.props.fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: sim/pe_dot8_properties.sv
// timing and X rules on the processing element outputs,
// bound into pe_dot8

module pe_dot8_properties import pe_pkg::*; (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic final_in,
	input logic valid_out,
	input acc_t mac_sum,
	input acc_t act_sum
);

	timeunit 1ns;
	timeprecision 100ps;

	int         fail_count  = 0;
	// edges since the last reset edge, saturates
	logic [3:0] since_reset = '0;

	always @(posedge clk) begin
		if (reset) begin
			since_reset <= '0;
		end else if (since_reset != 4'hf) begin
			since_reset <= since_reset + 1'b1;
		end
	end

	// low during reset and one cycle after
	assert property (@(posedge clk) reset |=> (!valid_out) [*2])
		else begin
			fail_count++;
			$error("valid_out high during reset or the cycle after");
		end

	// pulse 7 edges after the sampling edge of a final beat
	assert property (@(posedge clk)
		(since_reset >= 4'd8) |-> (valid_out == $past(valid_in && final_in, 8)))
		else begin
			fail_count++;
			$error("valid_out does not follow the final beat by 7 cycles");
		end

	assert property (@(posedge clk) valid_out |-> !$isunknown({mac_sum, act_sum}))
		else begin
			fail_count++;
			$error("unknown bits on mac_sum or act_sum with valid_out high");
		end

endmodule

// File: sim/pe_checker.sv
// reference model for the processing element that predicts each group
// result from the inputs and compares it with the data at valid_out

module pe_checker import pe_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_in,
	input  logic     final_in,
	input  ele_row_t act_row,
	input  ele_row_t ker_row,
	input  bias_t    bias_in,
	input  logic     valid_out,
	input  acc_t     mac_sum,
	input  acc_t     act_sum,
	input  logic     end_of_test,
	output int       error_count,
	output int       pending_count
);

	timeunit 1ns;
	timeprecision 100ps;

	// sums of the group still open
	logic [31:0] part_mac = '0;
	logic [31:0] part_act = '0;
	// expected results in group order
	logic [31:0] exp_mac [$];
	logic [31:0] exp_act [$];
	int          errors   = 0;
	int          pending  = 0;
	logic        end_seen = 1'b0;

	assign error_count   = errors;
	assign pending_count = pending;

	always @(posedge clk) begin
		logic [31:0] want_mac;
		logic [31:0] want_act;
		// outputs come before the reset clear since a result may leave on a reset edge
		if (valid_out === 1'b1) begin
			if (exp_mac.size() == 0) begin
				$display("valid_out high at %0t with no group result expected", $time);
				errors++;
			end else begin
				want_mac = exp_mac.pop_front();
				want_act = exp_act.pop_front();
				if (mac_sum !== want_mac) begin
					$display("FAIL mac_sum: got %h, expected %h", mac_sum, want_mac);
					errors++;
				end
				if (act_sum !== want_act) begin
					$display("FAIL act_sum: got %h, expected %h", act_sum, want_act);
					errors++;
				end
			end
		end
		// reset drops the open group and everything in flight
		if (reset) begin
			part_mac = '0;
			part_act = '0;
			exp_mac.delete();
			exp_act.delete();
		end else if (valid_in) begin
			for (int i = 0; i < LANES; i++) begin
				part_mac += act_row[i*ELE_W +: ELE_W] * ker_row[i*ELE_W +: ELE_W];
				part_act += act_row[i*ELE_W +: ELE_W];
			end
			if (final_in) begin
				// mac wraps at 32 bits and the activation sum at 18
				exp_mac.push_back(part_mac + bias_in);
				exp_act.push_back(part_act & 32'h0003_ffff);
				part_mac = '0;
				part_act = '0;
			end
		end
		if (end_of_test && !end_seen) begin
			end_seen = 1'b1;
			if (exp_mac.size() != 0) begin
				$display("%0d group results never appeared on valid_out", exp_mac.size());
				errors++;
			end
		end
		pending <= exp_mac.size();
	end

endmodule

// File: design/pe_dot8.sv
// eight-lane dot-product processing element, MAC with bias
// plus activation group sum, fixed 7-cycle latency

module pe_dot8 import pe_pkg::*; #(
	parameter int OUT_W     = pe_pkg::OUT_W,
	parameter int ACT_SUM_W = pe_pkg::ACT_SUM_W
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_in,
	input  logic     final_in,
	input  ele_row_t act_row,
	input  ele_row_t ker_row,
	input  bias_t    bias_in,
	output logic     valid_out,
	output acc_t     mac_sum,
	output acc_t     act_sum
);

	// ============================================================
	// internal nets
	// ============================================================

	pe_stage_if tags ();

	acc_t     mac_beat;
	act_sum_t act_beat;
	acc_t     mac_group;
	act_sum_t act_group;

	// tag and bias alignment
	pe_stage_ctrl u_ctrl (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.final_in (final_in),
		.bias_in  (bias_in),
		.tags     (tags.ctrl)
	);

	// per-beat sums, both ready after E4
	pe_mult_tree u_mult_tree (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.act_row  (act_row),
		.ker_row  (ker_row),
		.beat_sum (mac_beat)
	);

	pe_act_tree u_act_tree (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.act_row  (act_row),
		.beat_sum (act_beat)
	);

	// group accumulation at E5
	pe_group_acc #(.WIDTH(OUT_W)) mac_acc (
		.clk       (clk),
		.reset     (reset),
		.beat_sum  (mac_beat),
		.tags      (tags.acc),
		.group_sum (mac_group)
	);

	pe_group_acc #(.WIDTH(ACT_SUM_W)) act_acc (
		.clk       (clk),
		.reset     (reset),
		.beat_sum  (act_beat),
		.tags      (tags.acc),
		.group_sum (act_group)
	);

	// bias at E6, outputs at E7
	pe_result_stage #(
		.OUT_W     (OUT_W),
		.ACT_SUM_W (ACT_SUM_W)
	) u_result (
		.clk       (clk),
		.reset     (reset),
		.mac_group (mac_group),
		.act_group (act_group),
		.tags      (tags.result),
		.valid_out (valid_out),
		.mac_sum   (mac_sum),
		.act_sum   (act_sum)
	);

endmodule

// File: design/pe_result_stage.sv
// result stage, adds the bias to the MAC group sum and
// registers both group results onto the outputs

module pe_result_stage import pe_pkg::*; #(
	parameter int OUT_W     = pe_pkg::OUT_W,
	parameter int ACT_SUM_W = pe_pkg::ACT_SUM_W
) (
	input  logic     clk,
	input  logic     reset,
	input  acc_t     mac_group,
	input  act_sum_t act_group,
	pe_stage_if.result tags,
	output logic     valid_out,
	output acc_t     mac_sum,
	output acc_t     act_sum
);

	logic [OUT_W-1:0]     mac_b;
	logic [ACT_SUM_W-1:0] act_b;

	// E6, bias add, result wraps modulo 2^32
	always_ff @(posedge clk) begin
		if (tags.add_final) begin
			mac_b <= mac_group + tags.bias;
			act_b <= act_group;
		end
	end

	// E7, outputs change only with valid_out and hold otherwise
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			mac_sum   <= '0;
			act_sum   <= '0;
		end else begin
			valid_out <= tags.out_final;
			if (tags.out_final) begin
				mac_sum <= mac_b;
				// activation sum zero-extended to the output word
				act_sum <= {{(OUT_W-ACT_SUM_W){1'b0}}, act_b};
			end
		end
	end

endmodule

// File: design/pe_group_acc.sv
// group accumulator, sums beat sums over a group and
// presents the group total when the final beat arrives

module pe_group_acc import pe_pkg::*; #(
	parameter int WIDTH = OUT_W
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [WIDTH-1:0] beat_sum,
	pe_stage_if.acc          tags,
	output logic [WIDTH-1:0] group_sum
);

	// ============================================================
	// running total
	// ============================================================

	// partial sum of the group so far, wraps at WIDTH bits
	logic [WIDTH-1:0] total;

	always_ff @(posedge clk) begin
		if (reset) begin
			total     <= '0;
			group_sum <= '0;
		end else if (tags.acc_valid) begin
			if (tags.acc_final) begin
				// close the group, final beat included
				group_sum <= total + beat_sum;
				// next group starts from zero
				total     <= '0;
			end else begin
				total <= total + beat_sum;
			end
		end
		// idle cycles inside a group leave everything as is
	end

	// group_sum holds until the next final, long enough
	// for the result stage to pick it up one cycle later

endmodule

// File: design/pe_act_tree.sv
// activation sum tree, adds the eight activations of a beat,
// latency matched to the product tree

module pe_act_tree import pe_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_in,
	input  ele_row_t act_row,
	output act_sum_t beat_sum
);

	ele_row_t           act_q;
	ele_t               act_e [LANES];
	logic [ELE_W:0]     sum1_q [LANES/2];
	logic [ELE_W+1:0]   sum2_q [LANES/4];
	logic [ELE_W+2:0]   sum3_q;

	// E0 capture, zeros when the beat is idle
	always_ff @(posedge clk) begin
		if (reset || !valid_in) begin
			act_q <= '0;
		end else begin
			act_q <= act_row;
		end
	end

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			act_e[i] = act_q[i*ELE_W +: ELE_W];
		end
	end

	// E1 to E3 adder levels
	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES/2; i++) begin
			sum1_q[i] <= act_e[2*i] + act_e[2*i+1];
		end
		for (int i = 0; i < LANES/4; i++) begin
			sum2_q[i] <= sum1_q[2*i] + sum1_q[2*i+1];
		end
		sum3_q <= sum2_q[0] + sum2_q[1];
		// E4, stands in for the multiply stage of the product tree
		beat_sum <= act_sum_t'(sum3_q);
	end

endmodule

// File: design/pe_mult_tree.sv
// product tree, captures one beat, multiplies the eight lanes
// and reduces the products in three registered adder levels

module pe_mult_tree import pe_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_in,
	input  ele_row_t act_row,
	input  ele_row_t ker_row,
	output acc_t     beat_sum
);

	ele_row_t act_q;
	ele_row_t ker_q;
	ele_t     act_e [LANES];
	ele_t     ker_e [LANES];
	prod_t    prod_q [LANES];

	// level sums grow one bit per level
	logic [2*ELE_W:0]   sum1_q [LANES/2];
	logic [2*ELE_W+1:0] sum2_q [LANES/4];

	// ============================================================
	// E0 input capture
	// ============================================================

	// idle beats enter as zeros, so they add nothing downstream
	always_ff @(posedge clk) begin
		if (reset || !valid_in) begin
			act_q <= '0;
			ker_q <= '0;
		end else begin
			act_q <= act_row;
			ker_q <= ker_row;
		end
	end

	// split into lanes, lane 0 is the low byte
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			act_e[i] = act_q[i*ELE_W +: ELE_W];
			ker_e[i] = ker_q[i*ELE_W +: ELE_W];
		end
	end

	// ============================================================
	// E1 products, E2 to E4 adder levels
	// ============================================================

	always_ff @(posedge clk) begin
		// unsigned 8x8, full 16-bit product
		for (int i = 0; i < LANES; i++) begin
			prod_q[i] <= act_e[i] * ker_e[i];
		end
		// pairs of products
		for (int i = 0; i < LANES/2; i++) begin
			sum1_q[i] <= prod_q[2*i] + prod_q[2*i+1];
		end
		// pairs of pairs
		for (int i = 0; i < LANES/4; i++) begin
			sum2_q[i] <= sum1_q[2*i] + sum1_q[2*i+1];
		end
		// last level widens to the MAC word
		beat_sum <= acc_t'(sum2_q[0]) + acc_t'(sum2_q[1]);
	end

endmodule

// File: design/pe_stage_ctrl.sv
// stage control, delays valid, final and bias so each tag
// lines up with the pipeline stage that consumes it

module pe_stage_ctrl import pe_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          valid_in,
	input  logic          final_in,
	input  bias_t         bias_in,
	pe_stage_if.ctrl      tags
);

	// ============================================================
	// tag delay lines
	// ============================================================

	// bit k holds the tag of the beat sampled k edges ago
	logic [5:1] valid_d;
	logic [7:1] final_d;

	// final only counts together with valid
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_d <= '0;
			final_d <= '0;
		end else begin
			valid_d <= {valid_d[4:1], valid_in};
			final_d <= {final_d[6:1], valid_in & final_in};
		end
	end

	// ============================================================
	// bias alignment
	// ============================================================

	// one slot per stage, so back-to-back finals keep their own bias
	bias_t bias_d [1:6];

	always_ff @(posedge clk) begin
		// first slot only moves on a final beat
		if (valid_in && final_in) begin
			bias_d[1] <= bias_in;
		end
		for (int i = 2; i <= 6; i++) begin
			bias_d[i] <= bias_d[i-1];
		end
	end

	// taps, stage 5 for accumulation, 6 for bias add, 7 for output
	assign tags.acc_valid = valid_d[5];
	assign tags.acc_final = final_d[5];
	assign tags.add_final = final_d[6];
	assign tags.bias      = bias_d[6];
	assign tags.out_final = final_d[7];

endmodule

// File: design/pe_stage_if.sv
// stage tags and bias from the control delay line
// to the group accumulators and the result stage

interface pe_stage_if import pe_pkg::*; ();

	// stage 5, seen by both accumulators
	logic  acc_valid;
	logic  acc_final;

	// stage 6, bias addition
	logic  add_final;
	bias_t bias;

	// stage 7, output load
	logic  out_final;

	// the control block drives every tag
	modport ctrl (
		output acc_valid,
		output acc_final,
		output add_final,
		output bias,
		output out_final
	);

	modport acc (
		input acc_valid,
		input acc_final
	);

	modport result (
		input add_final,
		input bias,
		input out_final
	);

endinterface

// File: design/pe_pkg.sv
// shared widths, lane count and vector types
// for the eight-lane dot-product processing element

package pe_pkg;

	// ============================================================
	// widths
	// ============================================================

	// bits per activation or kernel weight
	localparam int ELE_W = 8;
	// elements per beat, the tree depth of three levels depends on it
	localparam int LANES = 8;
	// MAC word and output word
	localparam int OUT_W = 32;
	// activation group sum, wraps modulo 2^18
	localparam int ACT_SUM_W = 18;

	// ============================================================
	// types
	// ============================================================

	// one element
	typedef logic [ELE_W-1:0] ele_t;
	// one beat, lane 0 in the low byte
	typedef logic [LANES*ELE_W-1:0] ele_row_t;
	// unsigned lane product
	typedef logic [2*ELE_W-1:0] prod_t;
	// beat sum, group sum or result
	typedef logic [OUT_W-1:0] acc_t;
	// per-beat or group activation sum
	typedef logic [ACT_SUM_W-1:0] act_sum_t;
	// bias, taken with the final beat
	typedef logic signed [OUT_W-1:0] bias_t;

endpackage
